// File: hdl/eth_pkg.sv
package eth_pkg;

   // CPU word address, bit 11 selects the buffers
   localparam int ETH_ADDR_W = 12;
   localparam int BUF_ADDR_W = 9;
   localparam int BUF_WORDS  = 1 << BUF_ADDR_W;
   localparam int NBYTES_W   = 11;

   // Register map
   localparam logic [ETH_ADDR_W-1:0] REG_STATUS    = ETH_ADDR_W'(0);
   localparam logic [ETH_ADDR_W-1:0] REG_DUMMY     = ETH_ADDR_W'(1);
   localparam logic [ETH_ADDR_W-1:0] REG_SEND      = ETH_ADDR_W'(2);
   localparam logic [ETH_ADDR_W-1:0] REG_RCVACK    = ETH_ADDR_W'(3);
   localparam logic [ETH_ADDR_W-1:0] REG_TX_NBYTES = ETH_ADDR_W'(4);
   localparam logic [ETH_ADDR_W-1:0] REG_SOFTRST   = ETH_ADDR_W'(5);
   localparam logic [ETH_ADDR_W-1:0] REG_CRC       = ETH_ADDR_W'(6);
   localparam logic [ETH_ADDR_W-1:0] REG_RCV_SIZE  = ETH_ADDR_W'(7);

   localparam logic [NBYTES_W-1:0] TX_NBYTES_RST = NBYTES_W'(46);

   // Frame layout
   localparam int         PREAMBLE_NIBBLES = 15;
   localparam logic [3:0] PREAMBLE_NIB     = 4'h5;
   localparam logic [3:0] SFD_NIB          = 4'hD;

   // First destination byte on the wire is bits 47:40
   localparam logic [47:0]         ETH_MAC_ADDR   = 48'h02_A5_3C_71_0E_49;
   localparam logic [47:0]         ETH_BCAST_ADDR = '1;
   localparam logic [NBYTES_W-1:0] MAC_BYTES      = NBYTES_W'(6);

   // CRC-32, register kept MSB first
   localparam logic [31:0] CRC_POLY    = 32'h04C11DB7;
   localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

   localparam logic [19:0] PHY_RST_CYCLES = 20'd255;

endpackage

// File: hdl/eth_buffer.sv
`timescale 1ns/1ps

module eth_buffer import eth_pkg::*; (
   input  logic                  clk,
   input  logic                  we,
   input  logic [BUF_ADDR_W-1:0] waddr,
   input  logic [31:0]           wdata,
   input  logic [BUF_ADDR_W-1:0] raddr,
   output logic [31:0]           rdata
);

   logic [31:0] mem [BUF_WORDS];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      // Read data one cycle after the address
      rdata <= mem[raddr];
   end

endmodule

// File: hdl/eth_crc.sv
`timescale 1ns/1ps

module eth_crc import eth_pkg::*; (
   input  logic        clk,
   input  logic        rst_int,
   input  logic        clr,
   input  logic        en,
   input  logic [7:0]  data,
   output logic [31:0] crc
);

   logic [31:0] crc_next;

   // Data bits enter LSB first
   always_comb begin
      crc_next = crc;
      for (int i = 0; i < 8; i++) begin
         if (crc_next[31] ^ data[i]) begin
            crc_next = {crc_next[30:0], 1'b0} ^ CRC_POLY;
         end else begin
            crc_next = {crc_next[30:0], 1'b0};
         end
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         crc <= '1;
      end else if (clr) begin
         crc <= '1;
      end else if (en) begin
         crc <= crc_next;
      end
   end

endmodule

// File: hdl/eth_tx.sv
`timescale 1ns/1ps

module eth_tx import eth_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_int,
   input  logic                  start,
   input  logic [NBYTES_W-1:0]   nbytes,
   output logic                  ready,
   output logic [BUF_ADDR_W-1:0] buf_raddr,
   input  logic [31:0]           buf_rdata,
   output logic                  mii_tx_en,
   output logic [3:0]            mii_txd
);

   typedef enum logic [1:0] {ST_IDLE, ST_PRE, ST_DATA, ST_FCS} state_t;

   state_t              state;
   logic [3:0]          cnt;
   logic [NBYTES_W-1:0] byte_cnt;
   logic [NBYTES_W-1:0] len;
   logic                nib;
   logic [7:0]          tx_byte;
   logic [7:0]          cur_byte;
   logic                at_byte;
   logic                load;
   logic [31:0]         crc;
   logic [31:0]         crc_rev;
   logic [31:0]         fcs;

   // byte_cnt points at the next byte, its word was requested a cycle ago
   assign buf_raddr = byte_cnt[NBYTES_W-1:2];
   assign cur_byte  = buf_rdata[8*byte_cnt[1:0] +: 8];

   // Byte boundary after the SFD and after each high nibble
   assign at_byte = (state == ST_PRE && cnt == 4'(PREAMBLE_NIBBLES)) ||
                    (state == ST_DATA && !nib);
   assign load    = at_byte && byte_cnt != len;

   assign crc_rev = {<<{crc}};
   assign fcs     = ~crc_rev;

   eth_crc crc_gen (
      .clk     (clk),
      .rst_int (rst_int),
      .clr     (state == ST_IDLE),
      .en      (load),
      .data    (cur_byte),
      .crc     (crc)
   );

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state     <= ST_IDLE;
         cnt       <= '0;
         byte_cnt  <= '0;
         len       <= '0;
         nib       <= 1'b0;
         ready     <= 1'b1;
         mii_tx_en <= 1'b0;
         mii_txd   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               ready <= 1'b1;
               if (start) begin
                  state     <= ST_PRE;
                  ready     <= 1'b0;
                  len       <= nbytes;
                  cnt       <= '0;
                  byte_cnt  <= '0;
                  nib       <= 1'b0;
                  mii_tx_en <= 1'b1;
                  mii_txd   <= PREAMBLE_NIB;
               end
            end
            ST_PRE: begin
               cnt <= cnt + 1'b1;
               if (cnt == 4'(PREAMBLE_NIBBLES - 1)) begin
                  mii_txd <= SFD_NIB;
               end else if (cnt != 4'(PREAMBLE_NIBBLES)) begin
                  mii_txd <= PREAMBLE_NIB;
               end
            end
            ST_DATA: begin
               if (nib) begin
                  mii_txd <= tx_byte[7:4];
                  nib     <= 1'b0;
               end
            end
            ST_FCS: begin
               cnt <= cnt + 1'b1;
               if (cnt == 4'd7) begin
                  state     <= ST_IDLE;
                  mii_tx_en <= 1'b0;
                  mii_txd   <= '0;
               end else begin
                  mii_txd <= fcs[4*cnt[2:0] + 4 +: 4];
               end
            end
         endcase

         // Next payload byte, or FCS once the payload is out
         if (load) begin
            state    <= ST_DATA;
            mii_txd  <= cur_byte[3:0];
            byte_cnt <= byte_cnt + 1'b1;
            nib      <= 1'b1;
         end else if (at_byte) begin
            state   <= ST_FCS;
            mii_txd <= fcs[3:0];
            cnt     <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         tx_byte <= cur_byte;
      end
   end

endmodule

// File: hdl/eth_rx.sv
`timescale 1ns/1ps

module eth_rx import eth_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_int,
   input  logic                  ack,
   input  logic                  mii_rx_dv,
   input  logic [3:0]            mii_rxd,
   output logic                  buf_we,
   output logic [BUF_ADDR_W-1:0] buf_waddr,
   output logic [31:0]           buf_wdata,
   output logic                  rcvd,
   output logic [NBYTES_W-1:0]   size,
   output logic [31:0]           crc
);

   typedef enum logic [1:0] {ST_IDLE, ST_PRE, ST_DATA, ST_SKIP} state_t;

   state_t              state;
   logic                nib;
   logic [3:0]          lo_nib;
   logic [7:0]          rx_byte;
   logic                byte_done;
   logic [NBYTES_W-1:0] byte_cnt;
   logic [31:0]         word;
   logic [47:0]         dst;
   logic                addr_ok;
   logic                keep;
   logic                accept;
   logic [31:0]         crc_acc;

   assign rx_byte   = {mii_rxd, lo_nib};
   assign byte_done = state == ST_DATA && mii_rx_dv && nib;
   assign buf_wdata = word;

   // Destination is only known after six bytes
   assign addr_ok = dst == ETH_MAC_ADDR || dst == ETH_BCAST_ADDR;
   assign keep    = byte_cnt < MAC_BYTES || addr_ok;
   assign accept  = byte_cnt >= MAC_BYTES && addr_ok;

   eth_crc crc_chk (
      .clk     (clk),
      .rst_int (rst_int),
      .clr     (state == ST_PRE),
      .en      (byte_done),
      .data    (rx_byte),
      .crc     (crc_acc)
   );

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state     <= ST_IDLE;
         nib       <= 1'b0;
         byte_cnt  <= '0;
         buf_we    <= 1'b0;
         buf_waddr <= '0;
         rcvd      <= 1'b0;
         size      <= '0;
         crc       <= '0;
      end else begin
         buf_we <= 1'b0;
         if (ack) begin
            rcvd <= 1'b0;
         end
         case (state)
            ST_IDLE: begin
               // A pending frame blocks new ones
               if (mii_rx_dv) begin
                  if (!rcvd && mii_rxd == PREAMBLE_NIB) begin
                     state <= ST_PRE;
                  end else begin
                     state <= ST_SKIP;
                  end
               end
            end
            ST_PRE: begin
               nib      <= 1'b0;
               byte_cnt <= '0;
               if (!mii_rx_dv) begin
                  state <= ST_IDLE;
               end else if (mii_rxd == SFD_NIB) begin
                  state <= ST_DATA;
               end else if (mii_rxd != PREAMBLE_NIB) begin
                  state <= ST_SKIP;
               end
            end
            ST_DATA: begin
               if (mii_rx_dv) begin
                  nib <= !nib;
                  if (nib) begin
                     byte_cnt <= byte_cnt + 1'b1;
                     if (byte_cnt[1:0] == 2'd3 && keep) begin
                        buf_we    <= 1'b1;
                        buf_waddr <= byte_cnt[NBYTES_W-1:2];
                     end
                  end
               end else begin
                  state <= ST_IDLE;
                  if (accept) begin
                     rcvd <= 1'b1;
                     size <= byte_cnt;
                     crc  <= crc_acc;
                     // Flush a partly filled last word
                     if (byte_cnt[1:0] != 2'd0) begin
                        buf_we    <= 1'b1;
                        buf_waddr <= byte_cnt[NBYTES_W-1:2];
                     end
                  end
               end
            end
            ST_SKIP: begin
               if (!mii_rx_dv) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_DATA && mii_rx_dv && !nib) begin
         lo_nib <= mii_rxd;
      end
      if (byte_done) begin
         if (byte_cnt[1:0] == 2'd0) begin
            word <= {24'd0, rx_byte};
         end else begin
            word[8*byte_cnt[1:0] +: 8] <= rx_byte;
         end
         if (byte_cnt < MAC_BYTES) begin
            dst <= {dst[39:0], rx_byte};
         end
      end
   end

endmodule

// File: hdl/eth_regs.sv
`timescale 1ns/1ps

module eth_regs import eth_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  valid,
   input  logic [3:0]            wstrb,
   input  logic [ETH_ADDR_W-1:0] addr,
   input  logic [31:0]           wdata,
   output logic                  ready,
   output logic [31:0]           rdata,
   input  logic [31:0]           buf_rdata,
   output logic                  tx_we,
   output logic                  tx_start,
   output logic                  rx_ack,
   output logic [NBYTES_W-1:0]   tx_nbytes,
   output logic                  soft_rst,
   input  logic                  tx_ready,
   input  logic                  rx_rcvd,
   input  logic [NBYTES_W-1:0]   rx_size,
   input  logic [31:0]           rx_crc,
   input  logic                  rx_dv,
   output logic                  phy_resetn,
   output logic                  rst_int
);

   logic        wr;
   logic        buf_sel;
   logic [31:0] rd_mux;
   logic [31:0] reg_rdata;
   logic [31:0] dummy;
   logic [19:0] phy_cnt;
   logic        dv_seen;

   assign wr      = valid && |wstrb;
   assign tx_we   = wr && addr[ETH_ADDR_W-1];
   assign rst_int = rst || soft_rst;

   // Buffer words come straight from the registered RAM output
   assign rdata = buf_sel ? buf_rdata : reg_rdata;

   // Bus handshake and soft reset pulse, on the external reset
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready    <= 1'b0;
         buf_sel  <= 1'b0;
         soft_rst <= 1'b0;
      end else begin
         ready    <= valid;
         soft_rst <= wr && addr == REG_SOFTRST && !soft_rst;
         if (valid) begin
            buf_sel <= addr[ETH_ADDR_W-1];
         end
      end
   end

   always_comb begin
      case (addr)
         REG_STATUS:    rd_mux = {28'd0, dv_seen, phy_resetn, rx_rcvd, tx_ready && phy_resetn};
         REG_DUMMY:     rd_mux = dummy;
         REG_TX_NBYTES: rd_mux = {{(32-NBYTES_W){1'b0}}, tx_nbytes};
         REG_CRC:       rd_mux = rx_crc;
         REG_RCV_SIZE:  rd_mux = {{(32-NBYTES_W){1'b0}}, rx_size};
         default:       rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (valid) begin
         reg_rdata <= rd_mux;
      end
   end

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         dummy     <= '0;
         tx_nbytes <= TX_NBYTES_RST;
         tx_start  <= 1'b0;
         rx_ack    <= 1'b0;
      end else begin
         // Send only when idle and the PHY is out of reset
         tx_start <= wr && addr == REG_SEND && tx_ready && phy_resetn;
         rx_ack   <= wr && addr == REG_RCVACK;
         if (wr && addr == REG_DUMMY) begin
            dummy <= wdata;
         end
         if (wr && addr == REG_TX_NBYTES) begin
            tx_nbytes <= wdata[NBYTES_W-1:0];
         end
      end
   end

   // PHY reset release timer
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
         dv_seen    <= 1'b0;
      end else begin
         if (phy_cnt != PHY_RST_CYCLES) begin
            phy_cnt <= phy_cnt + 1'b1;
         end else begin
            phy_resetn <= 1'b1;
         end
         if (phy_resetn && rx_dv) begin
            dv_seen <= 1'b1;
         end
      end
   end

endmodule

// File: hdl/eth_core.sv
`timescale 1ns/1ps

module eth_core import eth_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  valid,
   input  logic [3:0]            wstrb,
   input  logic [ETH_ADDR_W-1:0] addr,
   input  logic [31:0]           wdata,
   output logic                  ready,
   output logic [31:0]           rdata,
   output logic                  mii_tx_en,
   output logic [3:0]            mii_txd,
   input  logic                  mii_rx_dv,
   input  logic [3:0]            mii_rxd,
   output logic                  phy_resetn
);

   logic                  rst_int;
   logic                  soft_rst;
   logic                  tx_we;
   logic                  tx_start;
   logic                  rx_ack;
   logic [NBYTES_W-1:0]   tx_nbytes;
   logic                  tx_ready;
   logic                  rx_rcvd;
   logic [NBYTES_W-1:0]   rx_size;
   logic [31:0]           rx_crc;
   logic [BUF_ADDR_W-1:0] tx_raddr;
   logic [31:0]           tx_rdata;
   logic                  rx_we;
   logic [BUF_ADDR_W-1:0] rx_waddr;
   logic [31:0]           rx_wdata;
   logic [31:0]           rx_rdata;

   eth_regs regs (
      .clk        (clk),
      .rst        (rst),
      .valid      (valid),
      .wstrb      (wstrb),
      .addr       (addr),
      .wdata      (wdata),
      .ready      (ready),
      .rdata      (rdata),
      .buf_rdata  (rx_rdata),
      .tx_we      (tx_we),
      .tx_start   (tx_start),
      .rx_ack     (rx_ack),
      .tx_nbytes  (tx_nbytes),
      .soft_rst   (soft_rst),
      .tx_ready   (tx_ready),
      .rx_rcvd    (rx_rcvd),
      .rx_size    (rx_size),
      .rx_crc     (rx_crc),
      .rx_dv      (mii_rx_dv),
      .phy_resetn (phy_resetn),
      .rst_int    (rst_int)
   );

   // CPU writes, transmitter reads
   eth_buffer tx_buf (
      .clk   (clk),
      .we    (tx_we),
      .waddr (addr[BUF_ADDR_W-1:0]),
      .wdata (wdata),
      .raddr (tx_raddr),
      .rdata (tx_rdata)
   );

   // Receiver writes, CPU reads
   eth_buffer rx_buf (
      .clk   (clk),
      .we    (rx_we),
      .waddr (rx_waddr),
      .wdata (rx_wdata),
      .raddr (addr[BUF_ADDR_W-1:0]),
      .rdata (rx_rdata)
   );

   eth_tx tx (
      .clk       (clk),
      .rst_int   (rst_int),
      .start     (tx_start),
      .nbytes    (tx_nbytes),
      .ready     (tx_ready),
      .buf_raddr (tx_raddr),
      .buf_rdata (tx_rdata),
      .mii_tx_en (mii_tx_en),
      .mii_txd   (mii_txd)
   );

   eth_rx rx (
      .clk       (clk),
      .rst_int   (rst_int),
      .ack       (rx_ack),
      .mii_rx_dv (mii_rx_dv),
      .mii_rxd   (mii_rxd),
      .buf_we    (rx_we),
      .buf_waddr (rx_waddr),
      .buf_wdata (rx_wdata),
      .rcvd      (rx_rcvd),
      .size      (rx_size),
      .crc       (rx_crc)
   );

endmodule

// File: verif/tb_clk.sv
`timescale 1ns/1ps

module tb_clk (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // 20 ns period
   always #10 clk = ~clk;

endmodule

// File: verif/eth_core_assert.sv
`timescale 1ns/1ps

module eth_core_assert (
   input logic clk,
   input logic rst,
   input logic valid,
   input logic ready,
   input logic mii_tx_en,
   input logic phy_resetn,
   input logic tx_ready
);

   // Back to back ready needs a new access in between
   ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
      $past(ready) && ready |-> $past(valid))
      else $error("ready high two cycles in a row without valid");

   no_tx_in_phy_reset: assert property (@(posedge clk) disable iff (rst)
      $rose(mii_tx_en) |-> phy_resetn)
      else $error("mii_tx_en rose while the PHY is held in reset");

   busy_while_sending: assert property (@(posedge clk) disable iff (rst)
      mii_tx_en |-> !tx_ready)
      else $error("tx_ready high during a transmission");

endmodule

// File: verif/eth_core_tb.sv
`timescale 1ns/1ps

module eth_core_tb import eth_pkg::*; ();

   logic                  clk;
   logic                  rst;
   logic                  valid;
   logic [3:0]            wstrb;
   logic [ETH_ADDR_W-1:0] addr;
   logic [31:0]           wdata;
   logic                  ready;
   logic [31:0]           rdata;
   logic                  mii_tx_en;
   logic [3:0]            mii_txd;
   logic                  mii_rx_dv = 1'b0;
   logic [3:0]            mii_rxd = 4'd0;
   logic                  phy_resetn;

   int         errors = 0;
   int         tests = 0;
   int         en_run = 0;
   int         last_len = 0;
   int         bursts = 0;
   logic [7:0] frame [2048];

   tb_clk clk_gen (
      .clk (clk)
   );

   eth_core DUT (
      .clk        (clk),
      .rst        (rst),
      .valid      (valid),
      .wstrb      (wstrb),
      .addr       (addr),
      .wdata      (wdata),
      .ready      (ready),
      .rdata      (rdata),
      .mii_tx_en  (mii_tx_en),
      .mii_txd    (mii_txd),
      .mii_rx_dv  (mii_rx_dv),
      .mii_rxd    (mii_rxd),
      .phy_resetn (phy_resetn)
   );

   bind eth_core eth_core_assert chk (
      .clk        (clk),
      .rst        (rst),
      .valid      (valid),
      .ready      (ready),
      .mii_tx_en  (mii_tx_en),
      .phy_resetn (phy_resetn),
      .tx_ready   (tx_ready)
   );

   // MII loopback through one register stage
   always @(posedge clk) begin
      mii_rx_dv <= mii_tx_en;
      mii_rxd   <= mii_txd;
   end

   // Length and number of mii_tx_en bursts
   always @(posedge clk) begin
      if (mii_tx_en) begin
         en_run <= en_run + 1;
      end else if (en_run != 0) begin
         last_len <= en_run;
         bursts   <= bursts + 1;
         en_run   <= 0;
      end
   end

   task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
      errors++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
   endtask

   task automatic bus_access(input logic [ETH_ADDR_W-1:0] a, input logic [3:0] strb,
                             input logic [31:0] d, output logic [31:0] q);
      int n;
      n = 0;
      @(posedge clk);
      valid <= 1'b1;
      addr  <= a;
      wstrb <= strb;
      wdata <= d;
      @(posedge clk);
      valid <= 1'b0;
      wstrb <= 4'd0;
      @(posedge clk);
      while (!ready && n < 16) begin
         @(posedge clk);
         n++;
      end
      if (!ready) begin
         errors++;
         $display("Bus access to address 0x%03h got no ready", a);
      end
      q = rdata;
   endtask

   task automatic bus_write(input logic [ETH_ADDR_W-1:0] a, input logic [31:0] d);
      logic [31:0] unused;
      bus_access(a, 4'hF, d, unused);
   endtask

   task automatic bus_read(input logic [ETH_ADDR_W-1:0] a, output logic [31:0] q);
      bus_access(a, 4'h0, 32'd0, q);
   endtask

   task automatic wait_phy_release();
      int n;
      n = 0;
      while (!phy_resetn && n < 1000) begin
         @(posedge clk);
         n++;
      end
      if (!phy_resetn) begin
         errors++;
         $display("phy_resetn was not released within 1000 cycles");
      end
   endtask

   task automatic end_test(input string name, input int err_start);
      tests++;
      $display("%-26s %s", name, errors == err_start ? "ok" : "has errors");
   endtask

   // Destination first, then random bytes, packed low byte first
   task automatic load_frame(input logic [47:0] dst, input int nbytes);
      for (int i = 0; i < nbytes; i++) begin
         frame[i] = i < 6 ? dst[47 - 8*i -: 8] : 8'($urandom);
      end
      for (int w = 0; w < (nbytes + 3) / 4; w++) begin
         bus_write(12'h800 | 12'(w),
                   {frame[4*w+3], frame[4*w+2], frame[4*w+1], frame[4*w]});
      end
   endtask

   task automatic wait_burst(input int b0);
      int n;
      n = 0;
      while (bursts == b0 && n < 5000) begin
         @(posedge clk);
         n++;
      end
      if (bursts == b0) begin
         errors++;
         $display("No transmission seen on mii_tx_en");
      end
   endtask

   task automatic send_frame(input int nbytes);
      int b0;
      int exp_len;
      exp_len = PREAMBLE_NIBBLES + 1 + 2 * (nbytes + 4);
      bus_write(REG_TX_NBYTES, 32'(nbytes));
      b0 = bursts;
      bus_write(REG_SEND, 32'd1);
      wait_burst(b0);
      if (last_len != exp_len) begin
         mismatch("mii_tx_en length", 32'(last_len), 32'(exp_len));
      end
   endtask

   task automatic check_received(input int nbytes);
      logic [31:0] q;
      logic [31:0] mask;
      logic [31:0] expw;
      int          n;
      n = 0;
      bus_read(REG_STATUS, q);
      while (!q[1] && n < 20) begin
         bus_read(REG_STATUS, q);
         n++;
      end
      if (!q[1]) begin
         errors++;
         $display("rx_data_rcvd never set after the frame");
      end
      // Looped back frame has raised mii_rx_dv
      if (q[3] != 1'b1) begin
         mismatch("status rx_dv seen", {31'd0, q[3]}, 32'd1);
      end
      bus_read(REG_RCV_SIZE, q);
      if (q != 32'(nbytes + 4)) begin
         mismatch("REG_RCV_SIZE", q, 32'(nbytes + 4));
      end
      // Only payload bytes, the FCS fills the rest of the last word
      for (int w = 0; w < (nbytes + 3) / 4; w++) begin
         bus_read(12'h800 | 12'(w), q);
         mask = '0;
         for (int b = 0; b < 4; b++) begin
            if (4*w + b < nbytes) begin
               mask[8*b +: 8] = 8'hFF;
            end
         end
         expw = {frame[4*w+3], frame[4*w+2], frame[4*w+1], frame[4*w]};
         if ((q & mask) != (expw & mask)) begin
            mismatch($sformatf("rx buffer word %0d", w), q & mask, expw & mask);
         end
      end
      bus_read(REG_CRC, q);
      if (q != CRC_RESIDUE) begin
         mismatch("REG_CRC", q, CRC_RESIDUE);
      end
   endtask

   task automatic phy_reset_status();
      int          e0;
      logic [31:0] q;
      e0 = errors;
      wait_phy_release();
      bus_read(REG_STATUS, q);
      if (q[0] != 1'b1) begin
         mismatch("status tx_ready", {31'd0, q[0]}, 32'd1);
      end
      if (q[1] != 1'b0) begin
         mismatch("status rx_data_rcvd", {31'd0, q[1]}, 32'd0);
      end
      if (q[2] != 1'b1) begin
         mismatch("status phy_resetn", {31'd0, q[2]}, 32'd1);
      end
      // No receive traffic yet, unused bits read zero
      if (q[31:3] != '0) begin
         mismatch("status bits 31:3", {3'd0, q[31:3]}, 32'd0);
      end
      end_test("phy reset and status", e0);
   endtask

   task automatic scratch_and_soft_reset();
      int          e0;
      logic [31:0] v;
      logic [31:0] q;
      e0 = errors;
      for (int i = 0; i < 4; i++) begin
         v = $urandom;
         bus_write(REG_DUMMY, v);
         bus_read(REG_DUMMY, q);
         if (q != v) begin
            mismatch("REG_DUMMY", q, v);
         end
      end
      bus_write(REG_SOFTRST, 32'd1);
      bus_read(REG_DUMMY, q);
      if (q != 32'd0) begin
         mismatch("REG_DUMMY after soft reset", q, 32'd0);
      end
      // Soft reset restarts the PHY timer too
      wait_phy_release();
      end_test("scratch and soft reset", e0);
   endtask

   task automatic loopback_broadcast();
      int e0;
      e0 = errors;
      load_frame(ETH_BCAST_ADDR, 64);
      send_frame(64);
      check_received(64);
      end_test("loopback broadcast frame", e0);
   endtask

   task automatic own_address_frame();
      int          e0;
      logic [31:0] q;
      e0 = errors;
      bus_write(REG_RCVACK, 32'd1);
      bus_read(REG_STATUS, q);
      if (q[1] != 1'b0) begin
         mismatch("status rx_data_rcvd after ack", {31'd0, q[1]}, 32'd0);
      end
      load_frame(ETH_MAC_ADDR, 50);
      send_frame(50);
      check_received(50);
      end_test("own address frame", e0);
   endtask

   task automatic foreign_address_drop();
      int          e0;
      logic [31:0] size0;
      logic [31:0] q;
      e0 = errors;
      bus_write(REG_RCVACK, 32'd1);
      bus_read(REG_RCV_SIZE, size0);
      load_frame(48'h02_00_5E_10_20_30, 46);
      send_frame(46);
      // rx_rcvd would rise within a few cycles
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
      end
      bus_read(REG_STATUS, q);
      if (q[1] != 1'b0) begin
         mismatch("status rx_data_rcvd", {31'd0, q[1]}, 32'd0);
      end
      bus_read(REG_RCV_SIZE, q);
      if (q != size0) begin
         mismatch("REG_RCV_SIZE", q, size0);
      end
      end_test("foreign address dropped", e0);
   endtask

   task automatic busy_send_ignored();
      int e0;
      int b0;
      int exp_len;
      e0 = errors;
      exp_len = PREAMBLE_NIBBLES + 1 + 2 * (60 + 4);
      load_frame(ETH_BCAST_ADDR, 60);
      bus_write(REG_TX_NBYTES, 32'd60);
      b0 = bursts;
      bus_write(REG_SEND, 32'd1);
      // Second send lands while the first frame is going out
      bus_write(REG_SEND, 32'd1);
      wait_burst(b0);
      for (int i = 0; i < 100; i++) begin
         @(posedge clk);
      end
      if (bursts != b0 + 1 || en_run != 0) begin
         mismatch("mii_tx_en bursts", 32'(bursts - b0), 32'd1);
      end
      if (last_len != exp_len) begin
         mismatch("mii_tx_en length", 32'(last_len), 32'(exp_len));
      end
      end_test("send while busy", e0);
   endtask

   initial begin
      void'($urandom(32'h4019_f783));
      rst   = 1'b1;
      valid = 1'b0;
      wstrb = 4'd0;
      addr  = '0;
      wdata = 32'd0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      phy_reset_status();
      scratch_and_soft_reset();
      loopback_broadcast();
      own_address_frame();
      foreign_address_drop();
      busy_send_ignored();

      $display("tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: sim.f
hdl/eth_pkg.sv
hdl/eth_buffer.sv
hdl/eth_crc.sv
hdl/eth_tx.sv
hdl/eth_rx.sv
hdl/eth_regs.sv
hdl/eth_core.sv
verif/tb_clk.sv
verif/eth_core_assert.sv
verif/eth_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module eth_core_tb \
   -f sim.f -o eth_core_sim

out=$(./obj_dir/eth_core_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
   exit 0
fi
exit 1
